// ==== common/qspi_pkg.sv ====
package qspi_pkg;

    ////////////////////////////////////////////////////////////
    // Register map in words on the 6-bit register bus
    ////////////////////////////////////////////////////////////

    localparam logic [5:0] REG_CCR     = 6'd0;
    localparam logic [5:0] REG_ADR     = 6'd1;
    localparam logic [5:0] REG_STA     = 6'd2;
    localparam logic [5:0] REG_DR_BASE = 6'd8;

    // Lowest bit of each CCR field
    localparam int CCR_CMD        = 0;
    localparam int CCR_MODE       = 8;
    localparam int CCR_WRITE      = 10;
    localparam int CCR_ADDR_BYTES = 11;
    localparam int CCR_DUMMY      = 16;
    localparam int CCR_SIZE       = 24;

    // The prescaler sits in the top bits of ADR, the flash address in bits 23:0
    localparam int CCR_PRESC_W = 6;
    localparam int ADR_PRESC   = 26;

    ////////////////////////////////////////////////////////////
    // Lane modes and transfer phases
    ////////////////////////////////////////////////////////////

    localparam logic [1:0] MODE_NONE = 2'd0;
    localparam logic [1:0] MODE_X1   = 2'd1;
    localparam logic [1:0] MODE_X2   = 2'd2;
    localparam logic [1:0] MODE_X4   = 2'd3;

    localparam logic [2:0] PHASE_IDLE  = 3'd0;
    localparam logic [2:0] PHASE_CMD   = 3'd1;
    localparam logic [2:0] PHASE_ADDR  = 3'd2;
    localparam logic [2:0] PHASE_DUMMY = 3'd3;
    localparam logic [2:0] PHASE_DATA  = 3'd4;

    // Data buffer depth
    localparam int BUF_WORDS = 8;
    localparam int BUF_BYTES = 32;

endpackage

// ==== qspi_engine/qspi_clock_gen.sv ====
`timescale 1ns/1ps

module qspi_clock_gen import qspi_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   run_i,
    input  logic [CCR_PRESC_W-1:0] presc_i,
    output logic                   sclk_o,
    output logic                   launch_o,
    output logic                   sample_o
);

    logic [CCR_PRESC_W-1:0] cnt_q;
    logic                   sclk_q;
    logic                   primed_q;
    logic                   launch_q;
    logic                   sample_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q    <= '0;
            sclk_q   <= 1'b0;
            primed_q <= 1'b0;
            launch_q <= 1'b0;
            sample_q <= 1'b0;
        end else begin
            launch_q <= 1'b0;
            sample_q <= 1'b0;
            if (!run_i) begin
                cnt_q    <= '0;
                sclk_q   <= 1'b0;
                primed_q <= 1'b0;
            end else if (cnt_q == presc_i) begin
                cnt_q <= '0;
                // The first half period only puts bit 7 on the bus, sclk stays low
                if (!primed_q) begin
                    primed_q <= 1'b1;
                    launch_q <= 1'b1;
                end else if (sclk_q) begin
                    sclk_q   <= 1'b0;
                    launch_q <= 1'b1;
                end else begin
                    sclk_q   <= 1'b1;
                    sample_q <= 1'b1;
                end
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign sclk_o   = sclk_q;
    assign launch_o = launch_q;
    assign sample_o = sample_q;

    assert property (@(posedge clk_i) disable iff (!rst_ni) !(launch_o && sample_o));

endmodule

// ==== qspi_engine/qspi_sequencer.sv ====
`timescale 1ns/1ps

module qspi_sequencer import qspi_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       start_i,
    input  logic       launch_i,
    input  logic       sample_i,
    input  logic [1:0] addr_bytes_i,
    input  logic [4:0] dummy_i,
    input  logic [1:0] mode_i,
    input  logic [4:0] size_i,
    output logic       cs_no,
    output logic       run_o,
    output logic [2:0] phase_o,
    output logic [2:0] bit_idx_o,
    output logic [4:0] byte_idx_o,
    output logic       done_o
);

    logic [2:0] phase_q;
    logic [2:0] bit_q;
    logic [4:0] byte_q;
    logic       cs_nq;
    logic       run_q;
    logic       done_q;
    logic       launched_q;

    logic [3:0] step;
    logic       byte_end;
    logic       phase_end;
    logic [2:0] nxt_phase;
    logic [2:0] to_data;
    logic [2:0] to_dummy;
    logic [2:0] to_addr;

    // Bits per sclk, only data may use more than one lane
    always_comb begin
        step = 4'd1;
        if (phase_q == PHASE_DATA) begin
            case (mode_i)
                MODE_X2: step = 4'd2;
                MODE_X4: step = 4'd4;
                default: step = 4'd1;
            endcase
        end
    end

    assign byte_end = ({1'b0, bit_q} + step) == 4'd8;

    // Skipped phases collapse into the next one that has work to do
    assign to_data  = (mode_i == MODE_NONE) ? PHASE_IDLE : PHASE_DATA;
    assign to_dummy = (dummy_i != 5'd0) ? PHASE_DUMMY : to_data;
    assign to_addr  = (addr_bytes_i != 2'd0) ? PHASE_ADDR : to_dummy;

    always_comb begin
        phase_end = 1'b0;
        nxt_phase = PHASE_IDLE;
        case (phase_q)
            PHASE_CMD: begin
                phase_end = byte_end;
                nxt_phase = to_addr;
            end
            PHASE_ADDR: begin
                phase_end = byte_end && (byte_q == 5'(addr_bytes_i) - 5'd1);
                nxt_phase = to_dummy;
            end
            // Byte counter doubles as the dummy clock counter here
            PHASE_DUMMY: begin
                phase_end = byte_q == dummy_i - 5'd1;
                nxt_phase = to_data;
            end
            PHASE_DATA: begin
                phase_end = byte_end && (byte_q == size_i);
                nxt_phase = PHASE_IDLE;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Phase FSM, stepped by sample strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q    <= PHASE_IDLE;
            bit_q      <= '0;
            byte_q     <= '0;
            cs_nq      <= 1'b1;
            run_q      <= 1'b0;
            done_q     <= 1'b0;
            launched_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (launch_i) begin
                launched_q <= 1'b1;
            end
            if (start_i) begin
                phase_q    <= PHASE_CMD;
                bit_q      <= '0;
                byte_q     <= '0;
                cs_nq      <= 1'b0;
                run_q      <= 1'b1;
                launched_q <= 1'b0;
            end else if (sample_i && phase_q != PHASE_IDLE) begin
                if (phase_end) begin
                    phase_q <= nxt_phase;
                    bit_q   <= '0;
                    byte_q  <= '0;
                    if (nxt_phase == PHASE_IDLE) begin
                        cs_nq  <= 1'b1;
                        run_q  <= 1'b0;
                        done_q <= 1'b1;
                    end
                end else if (phase_q == PHASE_DUMMY) begin
                    byte_q <= byte_q + 5'd1;
                end else if (byte_end) begin
                    bit_q  <= '0;
                    byte_q <= byte_q + 5'd1;
                end else begin
                    bit_q <= bit_q + step[2:0];
                end
            end
        end
    end

    assign cs_no      = cs_nq;
    assign run_o      = run_q;
    assign phase_o    = phase_q;
    assign bit_idx_o  = bit_q;
    assign byte_idx_o = byte_q;
    assign done_o     = done_q;

    // The clock generator must put bit 7 out before the flash sees a rising edge
    assert property (@(posedge clk_i) disable iff (!rst_ni) sample_i |-> launched_q);

endmodule

// ==== qspi_engine/qspi_shifter.sv ====
`timescale 1ns/1ps

module qspi_shifter import qspi_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        launch_i,
    input  logic        sample_i,
    input  logic [2:0]  phase_i,
    input  logic [2:0]  bit_idx_i,
    input  logic [4:0]  byte_idx_i,
    input  logic [1:0]  mode_i,
    input  logic        write_i,
    input  logic [7:0]  cmd_i,
    input  logic [23:0] addr_i,
    input  logic [7:0]  buf_rd_byte_i,
    input  logic [3:0]  lane_in_i,
    output logic [3:0]  lane_out_o,
    output logic [3:0]  lane_oe_o,
    output logic [4:0]  buf_rd_idx_o,
    output logic        buf_wr_o,
    output logic [4:0]  buf_wr_idx_o,
    output logic [7:0]  buf_wr_byte_o
);

    logic [3:0] lane_out_q;
    logic [3:0] lane_oe_q;
    logic       buf_wr_q;
    logic [4:0] wr_idx_q;
    logic [7:0] wr_byte_q;
    logic [7:0] shift_q;

    logic [2:0] msb;
    logic [4:0] addr_bit;
    logic [3:0] step;
    logic       last_bit;
    logic       capture;
    logic [7:0] shift_d;

    assign buf_rd_idx_o = byte_idx_i;
    assign msb          = 3'd7 - bit_idx_i;
    assign addr_bit     = 5'd23 - {byte_idx_i[1:0], bit_idx_i};
    assign capture      = sample_i && (phase_i == PHASE_DATA) && !write_i;
    assign last_bit     = ({1'b0, bit_idx_i} + step) == 4'd8;

    // Upper lanes carry the more significant bits of each group
    always_comb begin
        case (mode_i)
            MODE_X2: begin
                step    = 4'd2;
                shift_d = {shift_q[5:0], lane_in_i[1:0]};
            end
            MODE_X4: begin
                step    = 4'd4;
                shift_d = {shift_q[3:0], lane_in_i};
            end
            default: begin
                step    = 4'd1;
                shift_d = {shift_q[6:0], lane_in_i[1]};
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Transmit side, updated on the falling sclk edge
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lane_out_q <= '0;
            lane_oe_q  <= '0;
        end else if (phase_i == PHASE_IDLE) begin
            lane_oe_q <= '0;
        end else if (launch_i) begin
            lane_oe_q <= 4'b0000;
            case (phase_i)
                PHASE_CMD: begin
                    lane_out_q <= {3'b0, cmd_i[msb]};
                    lane_oe_q  <= 4'b0001;
                end
                PHASE_ADDR: begin
                    lane_out_q <= {3'b0, addr_i[addr_bit]};
                    lane_oe_q  <= 4'b0001;
                end
                PHASE_DATA: begin
                    if (write_i) begin
                        case (mode_i)
                            MODE_X2: begin
                                lane_out_q <= {2'b0, buf_rd_byte_i[msb -: 2]};
                                lane_oe_q  <= 4'b0011;
                            end
                            MODE_X4: begin
                                lane_out_q <= buf_rd_byte_i[msb -: 4];
                                lane_oe_q  <= 4'b1111;
                            end
                            default: begin
                                lane_out_q <= {3'b0, buf_rd_byte_i[msb]};
                                lane_oe_q  <= 4'b0001;
                            end
                        endcase
                    end
                end
                default: ;
            endcase
        end
    end

    // Receive side, a full byte is handed to the buffer one cycle after its last sample
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            buf_wr_q <= 1'b0;
        end else begin
            buf_wr_q <= capture && last_bit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            shift_q <= shift_d;
            if (last_bit) begin
                wr_byte_q <= shift_d;
                wr_idx_q  <= byte_idx_i;
            end
        end
    end

    assign lane_out_o    = lane_out_q;
    assign lane_oe_o     = lane_oe_q;
    assign buf_wr_o      = buf_wr_q;
    assign buf_wr_idx_o  = wr_idx_q;
    assign buf_wr_byte_o = wr_byte_q;

endmodule

// ==== qspi_master.f ====
common/qspi_pkg.sv
qspi_regs/qspi_regs.sv
qspi_engine/qspi_clock_gen.sv
qspi_engine/qspi_sequencer.sv
qspi_engine/qspi_shifter.sv
rtl/qspi_master.sv
testbench/qspi_checker.sv
testbench/tb_qspi_master.sv

// ==== qspi_regs/qspi_regs.sv ====
`timescale 1ns/1ps

module qspi_regs import qspi_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   write_i,
    input  logic [3:0]             be_i,
    input  logic [5:0]             addr_i,
    input  logic [31:0]            wdata_i,
    output logic [31:0]            rdata_o,
    input  logic                   done_i,
    input  logic [4:0]             buf_rd_idx_i,
    output logic [7:0]             buf_rd_byte_o,
    input  logic                   buf_wr_i,
    input  logic [4:0]             buf_wr_idx_i,
    input  logic [7:0]             buf_wr_byte_i,
    output logic                   start_o,
    output logic [7:0]             cmd_o,
    output logic [23:0]            addr_o,
    output logic [1:0]             addr_bytes_o,
    output logic [4:0]             dummy_o,
    output logic [1:0]             mode_o,
    output logic                   write_o,
    output logic [4:0]             size_o,
    output logic [CCR_PRESC_W-1:0] presc_o
);

    logic [31:0] ccr_q;
    logic [31:0] adr_q;
    logic        busy_q;
    logic        start_q;
    logic [7:0]  buf_q [BUF_BYTES];

    logic        cpu_wr;
    logic        dr_sel;
    logic [2:0]  word_idx;

    // The CPU cannot touch the setup while a transfer runs
    assign cpu_wr   = write_i && !busy_q;
    assign dr_sel   = (addr_i >= REG_DR_BASE) && (addr_i < REG_DR_BASE + BUF_WORDS);
    assign word_idx = 3'(addr_i - REG_DR_BASE);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ccr_q   <= '0;
            adr_q   <= '0;
            busy_q  <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (done_i) begin
                busy_q <= 1'b0;
            end
            if (cpu_wr && addr_i == REG_CCR) begin
                for (int b = 0; b < 4; b++) begin
                    if (be_i[b]) ccr_q[8*b +: 8] <= wdata_i[8*b +: 8];
                end
                // Writing the command byte kicks off the transfer
                if (be_i[0]) begin
                    busy_q  <= 1'b1;
                    start_q <= 1'b1;
                end
            end
            if (cpu_wr && addr_i == REG_ADR) begin
                for (int b = 0; b < 4; b++) begin
                    if (be_i[b]) adr_q[8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Byte k lives in word k/4 at lane k%4
    always_ff @(posedge clk_i) begin
        if (buf_wr_i) begin
            buf_q[buf_wr_idx_i] <= buf_wr_byte_i;
        end else if (cpu_wr && dr_sel) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) buf_q[{word_idx, 2'(b)}] <= wdata_i[8*b +: 8];
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        if (addr_i == REG_CCR) begin
            rdata_o = ccr_q;
        end else if (addr_i == REG_ADR) begin
            rdata_o = adr_q;
        end else if (addr_i == REG_STA) begin
            rdata_o = {31'b0, busy_q};
        end else if (dr_sel) begin
            rdata_o = {buf_q[{word_idx, 2'd3}], buf_q[{word_idx, 2'd2}],
                       buf_q[{word_idx, 2'd1}], buf_q[{word_idx, 2'd0}]};
        end
    end

    assign buf_rd_byte_o = buf_q[buf_rd_idx_i];
    assign start_o       = start_q;
    assign cmd_o         = ccr_q[CCR_CMD +: 8];
    assign mode_o        = ccr_q[CCR_MODE +: 2];
    assign write_o       = ccr_q[CCR_WRITE];
    assign addr_bytes_o  = ccr_q[CCR_ADDR_BYTES +: 2];
    assign dummy_o       = ccr_q[CCR_DUMMY +: 5];
    assign size_o        = ccr_q[CCR_SIZE +: 5];
    assign presc_o       = adr_q[ADR_PRESC +: CCR_PRESC_W];

    // Address is left-aligned so the shifter always starts from bit 23
    assign addr_o = adr_q[23:0] << {2'd3 - addr_bytes_o, 3'b000};

    // Received bytes may only land in the buffer during a transfer
    assert property (@(posedge clk_i) disable iff (!rst_ni) buf_wr_i |-> busy_q);

endmodule

// ==== rtl/qspi_master.sv ====
`timescale 1ns/1ps

module qspi_master (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        write_i,
    input  logic [3:0]  be_i,
    input  logic [5:0]  addr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o,
    output logic        sclk_o,
    output logic        cs_no,
    inout  wire  [3:0]  io
);

    logic        start;
    logic        done;
    logic [7:0]  cmd;
    logic [23:0] addr;
    logic [1:0]  addr_bytes;
    logic [4:0]  dummy;
    logic [1:0]  mode;
    logic        write;
    logic [4:0]  size;
    logic [5:0]  presc;

    logic        run;
    logic        launch;
    logic        sample;
    logic [2:0]  phase;
    logic [2:0]  bit_idx;
    logic [4:0]  byte_idx;

    logic [4:0]  buf_rd_idx;
    logic [7:0]  buf_rd_byte;
    logic        buf_wr;
    logic [4:0]  buf_wr_idx;
    logic [7:0]  buf_wr_byte;

    logic [3:0]  lane_out;
    logic [3:0]  lane_oe;

    qspi_regs i_qspi_regs (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .write_i       (write_i),
        .be_i          (be_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .rdata_o       (rdata_o),
        .done_i        (done),
        .buf_rd_idx_i  (buf_rd_idx),
        .buf_rd_byte_o (buf_rd_byte),
        .buf_wr_i      (buf_wr),
        .buf_wr_idx_i  (buf_wr_idx),
        .buf_wr_byte_i (buf_wr_byte),
        .start_o       (start),
        .cmd_o         (cmd),
        .addr_o        (addr),
        .addr_bytes_o  (addr_bytes),
        .dummy_o       (dummy),
        .mode_o        (mode),
        .write_o       (write),
        .size_o        (size),
        .presc_o       (presc)
    );

    qspi_clock_gen i_qspi_clock_gen (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .run_i    (run),
        .presc_i  (presc),
        .sclk_o   (sclk_o),
        .launch_o (launch),
        .sample_o (sample)
    );

    qspi_sequencer i_qspi_sequencer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start),
        .launch_i     (launch),
        .sample_i     (sample),
        .addr_bytes_i (addr_bytes),
        .dummy_i      (dummy),
        .mode_i       (mode),
        .size_i       (size),
        .cs_no        (cs_no),
        .run_o        (run),
        .phase_o      (phase),
        .bit_idx_o    (bit_idx),
        .byte_idx_o   (byte_idx),
        .done_o       (done)
    );

    qspi_shifter i_qspi_shifter (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .launch_i      (launch),
        .sample_i      (sample),
        .phase_i       (phase),
        .bit_idx_i     (bit_idx),
        .byte_idx_i    (byte_idx),
        .mode_i        (mode),
        .write_i       (write),
        .cmd_i         (cmd),
        .addr_i        (addr),
        .buf_rd_byte_i (buf_rd_byte),
        .lane_in_i     (io),
        .lane_out_o    (lane_out),
        .lane_oe_o     (lane_oe),
        .buf_rd_idx_o  (buf_rd_idx),
        .buf_wr_o      (buf_wr),
        .buf_wr_idx_o  (buf_wr_idx),
        .buf_wr_byte_o (buf_wr_byte)
    );

    // Each lane is released when the shifter does not drive it
    for (genvar i = 0; i < 4; i++) begin : g_io
        assign io[i] = lane_oe[i] ? lane_out[i] : 1'bz;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_qspi_master -f qspi_master.f -o sim_qspi

./obj_dir/sim_qspi > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
grep -q "TESTBENCH PASSED" sim.log

// ==== testbench/qspi_checker.sv ====
`timescale 1ns/1ps

module qspi_checker (
    input logic       clk_i,
    input logic       rst_ni,
    input logic       sclk_i,
    input logic       cs_ni,
    input logic [3:0] lane_oe_i
);

    int    n_pass = 0;
    int    n_fail = 0;
    int    errs = 0;
    int    rises = 0;
    int    run_len = 0;
    int    half_exp = 1;
    int    dummy_lo = 1;
    int    dummy_hi = 0;
    bit    seen_edge = 1'b0;
    bit    sclk_prev = 1'b0;
    bit    bad_period = 1'b0;
    bit    bad_oe = 1'b0;
    string test_name;

    // Pins are looked at on the falling clk edge, half a cycle after they change
    always @(negedge clk_i) begin
        if (!rst_ni || cs_ni) begin
            seen_edge = 1'b0;
            sclk_prev = 1'b0;
            run_len   = 0;
        end else if (sclk_i != sclk_prev) begin
            // The low time ahead of the first rising edge also holds the setup launch
            if (seen_edge && run_len != half_exp) bad_period = 1'b1;
            if (sclk_i) begin
                rises++;
                if (rises >= dummy_lo && rises <= dummy_hi && lane_oe_i != 4'b0) bad_oe = 1'b1;
            end
            seen_edge = 1'b1;
            sclk_prev = sclk_i;
            run_len   = 1;
        end else begin
            run_len++;
        end
    end

    task automatic begin_test(input string name, input int presc, input int lo, input int hi);
        test_name  = name;
        half_exp   = presc + 1;
        dummy_lo   = lo;
        dummy_hi   = hi;
        errs       = 0;
        rises      = 0;
        bad_period = 1'b0;
        bad_oe     = 1'b0;
    endtask

    task automatic check_val(input string sig, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, sig, exp, act);
            errs++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t in test %s: %s", $time, test_name, msg);
        errs++;
    endtask

    task automatic end_test(input int exp_rises);
        check_val("sclk_rises", exp_rises, rises);
        if (bad_period) report_error($sformatf("an sclk half period was not %0d clk cycles",
                                               half_exp));
        if (bad_oe) report_error("the DUT drove an io lane during the dummy clocks");
        if (errs == 0) begin
            n_pass++;
            $display("[PASS] %0t %s", $time, test_name);
        end else begin
            n_fail++;
            $display("[FAIL] %0t %s finished with %0d failed checks", $time, test_name, errs);
        end
    endtask

    task automatic summary();
        $display("Tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    endtask

endmodule

// ==== testbench/qspi_trace.txt ====
# name cmd mode write addr_bytes addr dummy bytes presc busy_poke, all hex: cmd addr words
# then eight data words, flash read data for reads and buffer contents for writes
cmd_only 06 0 0 0 000000 0 1 1 0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
x1_read 03 1 0 3 123456 0 8 1 0 a5a55a5a 01234567 00000000 00000000 00000000 00000000 00000000 00000000
x2_read bb 2 0 3 00abcd 8 16 2 0 c3b2a190 0f1e2d3c 55aa33cc 87654321 00000000 00000000 00000000 00000000
x4_write 32 3 1 3 001000 0 16 1 0 deadbeef 13579bdf 2468ace0 f00dcafe 00000000 00000000 00000000 00000000
presc_3 0b 1 0 3 000200 8 4 3 0 6c5b4a39 00000000 00000000 00000000 00000000 00000000 00000000 00000000
busy_ignore 03 1 0 3 000040 0 8 2 1 11223344 99aabbcc 00000000 00000000 00000000 00000000 00000000 00000000
x4_read eb 3 0 3 7fff00 6 32 1 0 00112233 44556677 8899aabb ccddeeff 0f0e0d0c 0b0a0908 07060504 03020100
x1_write 02 1 1 2 003456 0 5 1 0 76543210 000000fe 00000000 00000000 00000000 00000000 00000000 00000000

// ==== testbench/tb_qspi_master.sv ====
`timescale 1ns/1ps

module tb_qspi_master import qspi_pkg::*; ();

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        write_i;
    logic [3:0]  be_i;
    logic [5:0]  addr_i;
    logic [31:0] wdata_i;
    logic [31:0] rdata_o;
    logic        sclk_o;
    logic        cs_no;
    wire  [3:0]  io;

    // Flash model state
    logic [3:0]  fl_oe = '0;
    logic [3:0]  fl_out = '0;
    int          fl_rise = 0;
    logic [7:0]  fl_cmd;
    logic [23:0] fl_addr;
    logic [7:0]  fl_rd [32];
    logic [7:0]  fl_wr [32];

    // Transfer setup of the running test, shared with the flash model
    int          cfg_mode = 0;
    int          cfg_write = 0;
    int          cfg_ab = 0;
    int          cfg_dummy = 0;
    int          cfg_bytes = 1;
    logic [7:0]  exp_buf [32];

    always #20 clk_i = ~clk_i;

    qspi_master i_qspi_master (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .write_i (write_i),
        .be_i    (be_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .sclk_o  (sclk_o),
        .cs_no   (cs_no),
        .io      (io)
    );

    qspi_checker u_checker (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .sclk_i    (sclk_o),
        .cs_ni     (cs_no),
        .lane_oe_i (i_qspi_master.lane_oe)
    );

    for (genvar i = 0; i < 4; i++) begin : g_flash_io
        assign io[i] = fl_oe[i] ? fl_out[i] : 1'bz;
    end

    function automatic int lane_count(int mode);
        if (mode == 3) return 4;
        if (mode == 2) return 2;
        return 1;
    endfunction

    function automatic int edges_before_data();
        return 8 + 8 * cfg_ab + cfg_dummy;
    endfunction

    ////////////////////////////////////////////////////////////
    // Behavioural flash, mode 0
    ////////////////////////////////////////////////////////////

    always @(negedge cs_no) begin
        fl_rise = 0;
        fl_cmd  = '0;
        fl_addr = '0;
    end

    always @(posedge cs_no) fl_oe = '0;

    always @(posedge sclk_o) begin : flash_capture
        int l;
        int g;
        int b;
        l = lane_count(cfg_mode);
        if (!cs_no) begin
            fl_rise++;
            g = fl_rise - edges_before_data() - 1;
            if (fl_rise <= 8) begin
                fl_cmd = {fl_cmd[6:0], io[0]};
            end else if (fl_rise <= 8 + 8 * cfg_ab) begin
                fl_addr = {fl_addr[22:0], io[0]};
            end else if (g >= 0 && cfg_write != 0 && cfg_mode != 0 && g < cfg_bytes * 8 / l) begin
                b = g / (8 / l);
                case (l)
                    4: fl_wr[b] = {fl_wr[b][3:0], io};
                    2: fl_wr[b] = {fl_wr[b][5:0], io[1:0]};
                    default: fl_wr[b] = {fl_wr[b][6:0], io[0]};
                endcase
            end
        end
    end

    // Read data goes out on the falling edge ahead of the rising edge that samples it
    always @(negedge sclk_o) begin : flash_drive
        int l;
        int g;
        logic [7:0] bits;
        l = lane_count(cfg_mode);
        g = fl_rise - edges_before_data();
        if (!cs_no && cfg_write == 0 && cfg_mode != 0 && g >= 0 && g < cfg_bytes * 8 / l) begin
            bits = fl_rd[g / (8 / l)] >> (8 - l * (g % (8 / l) + 1));
            case (l)
                4: begin
                    fl_oe  = 4'b1111;
                    fl_out = bits[3:0];
                end
                2: begin
                    fl_oe  = 4'b0011;
                    fl_out = {2'b00, bits[1:0]};
                end
                default: begin
                    fl_oe  = 4'b0010;
                    fl_out = {2'b00, bits[0], 1'b0};
                end
            endcase
        end else begin
            fl_oe = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Register port access
    ////////////////////////////////////////////////////////////

    task automatic write_reg(input logic [5:0] a, input logic [31:0] d);
        @(negedge clk_i);
        write_i = 1'b1;
        be_i    = 4'hf;
        addr_i  = a;
        wdata_i = d;
        @(negedge clk_i);
        write_i = 1'b0;
    endtask

    task automatic read_reg(input logic [5:0] a, output logic [31:0] d);
        @(negedge clk_i);
        addr_i = a;
        #1;
        d = rdata_o;
    endtask

    task automatic wait_idle(output bit ok);
        logic [31:0] d;
        ok = 1'b0;
        for (int n = 0; n < 4000 && !ok; n++) begin
            read_reg(REG_STA, d);
            if (!d[0]) ok = 1'b1;
        end
    endtask

    initial begin
        int fd;
        int code;
        string line;
        logic [127:0] name;
        logic [31:0] cmd, mode, wr, ab, addr, dummy, nbytes, presc, poke;
        logic [31:0] dw [8];
        logic [31:0] ccr;
        logic [31:0] d;
        bit ok;
        bit aborted;
        write_i = 1'b0;
        be_i    = '0;
        addr_i  = '0;
        wdata_i = '0;
        rst_ni  = 1'b0;
        void'($urandom(32'h14c6));
        repeat (3) @(negedge clk_i);
        rst_ni  = 1'b1;
        aborted = 1'b0;
        fd = $fopen("testbench/qspi_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file testbench/qspi_trace.txt");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code <= 1 || line.getc(0) == 8'h23) continue;
            code = $sscanf(line, "%s %h %d %d %d %h %d %d %d %d %h %h %h %h %h %h %h %h",
                name, cmd, mode, wr, ab, addr, dummy, nbytes, presc, poke,
                dw[0], dw[1], dw[2], dw[3], dw[4], dw[5], dw[6], dw[7]);
            if (code != 18) begin
                $display("A line of the trace file does not hold all its fields");
                aborted = 1'b1;
                continue;
            end
            cfg_mode  = mode;
            cfg_write = wr;
            cfg_ab    = ab;
            cfg_dummy = dummy;
            cfg_bytes = nbytes;
            // Unused buffer bytes get random filler so stray writes show up
            for (int b = 0; b < 32; b++) begin
                fl_rd[b]   = dw[b / 4][8 * (b % 4) +: 8];
                fl_wr[b]   = '0;
                exp_buf[b] = (wr != 0 && b < nbytes) ? fl_rd[b] : 8'($urandom);
            end
            for (int w = 0; w < 8; w++) begin
                write_reg(REG_DR_BASE + 6'(w), {exp_buf[4*w+3], exp_buf[4*w+2],
                                                exp_buf[4*w+1], exp_buf[4*w]});
            end
            write_reg(REG_ADR, {presc[5:0], 2'b00, addr[23:0]});
            ccr = {3'b0, 5'(nbytes - 1), 3'b0, dummy[4:0], 3'b0, ab[1:0], wr[0], mode[1:0],
                   cmd[7:0]};
            u_checker.begin_test($sformatf("%0s", name), presc, 9 + 8 * ab, 8 + 8 * ab + dummy);
            write_reg(REG_CCR, ccr);
            if (poke != 0) begin
                write_reg(REG_CCR, ccr ^ 32'h00ff_00ff);
                // Word 7 lies outside the transfer, so an accepted write would stay visible
                write_reg(REG_DR_BASE + 6'd7, 32'hdead_beef);
            end
            wait_idle(ok);
            if (!ok) begin
                $display("Timeout in test %0s: busy did not clear", name);
                aborted = 1'b1;
            end else begin
                if (wr == 0 && mode != 0) begin
                    for (int b = 0; b < nbytes; b++) exp_buf[b] = fl_rd[b];
                end
                u_checker.check_val("flash_cmd", cmd[7:0], fl_cmd);
                if (ab != 0) begin
                    u_checker.check_val("flash_addr", addr & ((32'h1 << (8 * ab)) - 1), fl_addr);
                end
                if (wr != 0 && mode != 0) begin
                    for (int b = 0; b < nbytes; b++) begin
                        u_checker.check_val($sformatf("flash_data[%0d]", b), exp_buf[b], fl_wr[b]);
                    end
                end
                for (int w = 0; w < 8; w++) begin
                    read_reg(REG_DR_BASE + 6'(w), d);
                    u_checker.check_val($sformatf("dr[%0d]", w), {exp_buf[4*w+3], exp_buf[4*w+2],
                                        exp_buf[4*w+1], exp_buf[4*w]}, d);
                end
                read_reg(REG_CCR, d);
                u_checker.check_val("ccr", ccr, d);
                u_checker.end_test(8 + 8 * ab + dummy +
                                   (mode != 0 ? nbytes * 8 / lane_count(mode) : 0));
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        u_checker.summary();
        if (!aborted && u_checker.n_fail == 0 && u_checker.n_pass > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
